/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_game_view
FILELIST = compile.f

OBJDIR = obj_dir
LOG = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* compile.f */
verilog/gold_view_pkg.sv
verilog/background_drawer.sv
verilog/sprite_drawer.sv
verilog/object_map.sv
verilog/level_keeper.sv
verilog/view_sequencer.sv
verilog/game_view.sv
verif/game_view_chk.sv
verif/tb_game_view.sv

/* verif/game_view_chk.sv */
// game_view_chk assertions on pixel range, frame_done width and writes after game over
`default_nettype none

module game_view_chk import gold_view_pkg::*; (
	input logic           clk,
	input logic           resetn,
	input logic           write_en,
	input logic [X_W-1:0] x_out,
	input logic [Y_W-1:0] y_out,
	input logic           frame_done,
	input logic           game_over
);
	timeunit 1ns;
	timeprecision 1ps;

	// count of failed assertions
	int unsigned failures = 0;

	a_pixel_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		write_en |-> (x_out < X_W'(SCREEN_W)) && (y_out < Y_W'(SCREEN_H)))
	else begin
		failures++;
		$error("pixel write outside the screen");
	end

	a_frame_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
		frame_done |=> !frame_done)
	else begin
		failures++;
		$error("frame_done held for more than one cycle");
	end

	// drawing stops once the timer has run out
	a_quiet_after_game_over: assert property (@(posedge clk) disable iff (!resetn)
		game_over |-> !write_en)
	else begin
		failures++;
		$error("pixel write while game_over is set");
	end

endmodule

bind game_view game_view_chk i_game_view_chk (.*);

`default_nettype wire

/* verif/tb_game_view.sv */
// tb_game_view clock, reset, frame table stimulus, pixel scoreboard and checks
`default_nettype none

module tb_game_view import gold_view_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ROWS = 8;
	localparam int NO_GRAB = 15;
	localparam int BG_PIXELS = SCREEN_W * SCREEN_H;
	localparam int SPRITE_PIXELS = SPRITE_SIZE * SPRITE_SIZE;
	localparam int QUIET_CYCLES = 200;
	localparam int GRAB_DELAY = 100;
	localparam int MAX_CYCLES = NUM_ROWS * (BG_PIXELS + NUM_OBJECTS * 257 + 4) + 4000;

	logic clk;
	logic resetn;
	logic go;
	logic grab;
	logic [IDX_W-1:0] grab_index;
	logic [X_W-1:0] x_out;
	logic [Y_W-1:0] y_out;
	logic [COLOR_W-1:0] color_out;
	logic write_en;
	logic frame_done;
	logic [SCORE_W-1:0] score;
	logic [LEVEL_W-1:0] level;
	logic [TIME_W-1:0] time_left;
	logic game_over;

	// one row per frame with go, three grab indices, score, level, time_left and game_over
	// expected values hold one cycle after that frame's frame_done
	int frame_table [NUM_ROWS][8] = '{
		'{1, 12, 0, NO_GRAB, 0, 1, 4, 0},
		'{0, 13, 5, 5, 55, 1, 3, 0},
		'{0, 14, 1, 2, 0, 2, 4, 0},
		'{0, 6, NO_GRAB, NO_GRAB, 5, 2, 3, 0},
		'{0, NO_GRAB, NO_GRAB, NO_GRAB, 5, 2, 2, 0},
		'{0, 7, NO_GRAB, NO_GRAB, 10, 2, 1, 0},
		'{0, NO_GRAB, NO_GRAB, NO_GRAB, 10, 2, 0, 1},
		'{1, 3, NO_GRAB, NO_GRAB, 25, 0, 3, 0}
	};

	// reference model of the play field
	bit vis_model [NUM_OBJECTS];
	int obj_writes [NUM_OBJECTS];
	int pix_count = 0;
	int model_score = 0;
	int model_level = 0;
	int cycle_count = 0;
	int unsigned rng_state = 83139;

	game_view i_game_view (
		.clk, .resetn, .go, .grab, .grab_index,
		.x_out, .y_out, .color_out, .write_en, .frame_done,
		.score, .level, .time_left, .game_over
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic report_failure(string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check(string name, int actual, int expected);
		if (actual !== expected)
			report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
				name, actual, expected));
	endtask

	function automatic int unsigned next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 16;
	endfunction

	// layout rule puts object i at column i mod 5 and row i div 5
	function automatic int origin_x(int i);
		return MAP_X0 + MAP_DX * (i % MAP_COLS);
	endfunction

	function automatic int origin_y(int i);
		return MAP_Y0 + MAP_DY * (i / MAP_COLS);
	endfunction

	function automatic int kind_color(int i);
		if (i < NUM_GOLD)
			return int'(GOLD_COLOR);
		else if (i < NUM_GOLD + NUM_STONE)
			return int'(STONE_COLOR);
		return int'(DIAMOND_COLOR);
	endfunction

	function automatic int kind_value(int i);
		if (i < NUM_GOLD)
			return 25;
		else if (i < NUM_GOLD + NUM_STONE)
			return 5;
		return 50;
	endfunction

	function automatic int visible_count();
		int n;
		n = 0;
		for (int i = 0; i < NUM_OBJECTS; i++)
			n += int'(vis_model[i]);
		return n;
	endfunction

	// one-cycle grab with score compared two cycles later
	task automatic apply_grab(int idx);
		@(posedge clk);
		grab <= 1'b1;
		grab_index <= IDX_W'(idx);
		@(posedge clk);
		grab <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		if (idx < NUM_OBJECTS && vis_model[idx]) begin
			vis_model[idx] = 1'b0;
			model_score += kind_value(idx);
		end
		check("score", int'(score), model_score);
	endtask

	// grab an object that is already gone, picked at random
	task automatic grab_hidden();
		int hidden;
		int pick;
		int idx;
		hidden = NUM_OBJECTS - visible_count();
		if (hidden > 0) begin
			pick = next_random() % hidden;
			idx = 0;
			for (int i = 0; i < NUM_OBJECTS; i++) begin
				if (!vis_model[i]) begin
					if (pick == 0)
						idx = i;
					pick--;
				end
			end
			apply_grab(idx);
		end
	endtask

	task automatic expect_quiet(int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check("write_en", int'(write_en), 0);
		end
	endtask

	// pixel scoreboard, sampled away from the rising edge
	always @(negedge clk) begin
		int x;
		int y;
		int k;
		int hit;
		if (resetn && write_en) begin
			x = int'(x_out);
			y = int'(y_out);
			if (pix_count < BG_PIXELS) begin
				check("x_out", x, pix_count % SCREEN_W);
				check("y_out", y, pix_count / SCREEN_W);
				check("color_out", int'(color_out), int'(BG_COLOR));
			end else begin
				hit = -1;
				for (int i = 0; i < NUM_OBJECTS; i++)
					if (x >= origin_x(i) && x < origin_x(i) + SPRITE_SIZE &&
						y >= origin_y(i) && y < origin_y(i) + SPRITE_SIZE)
						hit = i;
				if (hit < 0) begin
					report_failure($sformatf("Object write at x=%0d y=%0d is outside every square",
						x, y));
				end else if (!vis_model[hit]) begin
					report_failure($sformatf("Hidden object %0d was drawn", hit));
				end else begin
					k = obj_writes[hit];
					check("x_out", x, origin_x(hit) + k % SPRITE_SIZE);
					check("y_out", y, origin_y(hit) + k / SPRITE_SIZE);
					check("color_out", int'(color_out), kind_color(hit));
					obj_writes[hit]++;
				end
			end
			pix_count++;
		end
		if (resetn && frame_done) begin
			for (int i = 0; i < NUM_OBJECTS; i++) begin
				check("object writes", obj_writes[i], vis_model[i] ? SPRITE_PIXELS : 0);
				obj_writes[i] = 0;
			end
			check("frame writes", pix_count, BG_PIXELS + SPRITE_PIXELS * visible_count());
			pix_count = 0;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (i_game_view.i_game_view_chk.failures != 0)
			report_failure("An assertion in the bound checker failed");
		if (cycle_count >= MAX_CYCLES)
			report_failure($sformatf("Timeout: the frames did not finish within %0d cycles",
				MAX_CYCLES));
	end

	initial begin
		resetn <= 1'b0;
		go <= 1'b0;
		grab <= 1'b0;
		grab_index <= '0;
		for (int i = 0; i < NUM_OBJECTS; i++) begin
			vis_model[i] = 1'b1;
			obj_writes[i] = 0;
		end
		repeat (8) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		check("score", int'(score), 0);
		check("level", int'(level), 0);
		check("time_left", int'(time_left), int'(ROUND_FRAMES));
		check("game_over", int'(game_over), 0);

		for (int r = 0; r < NUM_ROWS; r++) begin
			if (frame_table[r][0] != 0) begin
				expect_quiet(QUIET_CYCLES);
				@(posedge clk);
				go <= 1'b1;
				@(posedge clk);
				go <= 1'b0;
				for (int i = 0; i < NUM_OBJECTS; i++)
					vis_model[i] = 1'b1;
				model_score = 0;
				model_level = 0;
			end
			// grabs land well inside the background pass
			repeat (GRAB_DELAY) @(posedge clk);
			for (int g = 1; g <= 3; g++)
				if (frame_table[r][g] != NO_GRAB)
					apply_grab(frame_table[r][g]);
			grab_hidden();

			do @(negedge clk); while (!frame_done);
			@(negedge clk);
			check("score", int'(score), frame_table[r][4]);
			check("level", int'(level), frame_table[r][5]);
			check("time_left", int'(time_left), frame_table[r][6]);
			check("game_over", int'(game_over), frame_table[r][7]);
			// a level up brings every object back
			if (frame_table[r][5] != model_level)
				for (int i = 0; i < NUM_OBJECTS; i++)
					vis_model[i] = 1'b1;
			model_level = frame_table[r][5];
			model_score = frame_table[r][4];
		end

		if (i_game_view.i_game_view_chk.failures == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			report_failure("An assertion in the bound checker failed");
		end
	end

endmodule

`default_nettype wire

/* verilog/background_drawer.sv */
// background_drawer raster scan over the full screen
`default_nettype none

module background_drawer import gold_view_pkg::*; (
	input  logic           clk,
	input  logic           resetn,
	input  logic           bg_start,
	output logic [X_W-1:0] bg_x,
	output logic [Y_W-1:0] bg_y,
	output logic           bg_valid,
	output logic           bg_done
);

	logic x_last;
	logic y_last;

	assign x_last = bg_x == X_W'(SCREEN_W - 1);
	assign y_last = bg_y == Y_W'(SCREEN_H - 1);
	assign bg_done = bg_valid && x_last && y_last;

	// x runs fastest
	always_ff @(posedge clk) begin
		if (!resetn) begin
			bg_valid <= 1'b0;
			bg_x <= '0;
			bg_y <= '0;
		end else if (bg_start) begin
			bg_valid <= 1'b1;
			bg_x <= '0;
			bg_y <= '0;
		end else if (bg_valid) begin
			if (x_last) begin
				bg_x <= '0;
				bg_y <= bg_y + 1'b1;
				if (y_last)
					bg_valid <= 1'b0;
			end else begin
				bg_x <= bg_x + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/game_view.sv */
// game_view top level connecting sequencer, drawers, object map and level keeper
`default_nettype none

module game_view import gold_view_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic               go,
	input  logic               grab,
	input  logic [IDX_W-1:0]   grab_index,
	output logic [X_W-1:0]     x_out,
	output logic [Y_W-1:0]     y_out,
	output logic [COLOR_W-1:0] color_out,
	output logic               write_en,
	output logic               frame_done,
	output logic [SCORE_W-1:0] score,
	output logic [LEVEL_W-1:0] level,
	output logic [TIME_W-1:0]  time_left,
	output logic               game_over
);

	logic game_start;
	logic bg_start;
	logic sprite_start;
	logic [X_W-1:0] bg_x;
	logic [Y_W-1:0] bg_y;
	logic bg_valid;
	logic bg_done;
	logic [X_W-1:0] sprite_x;
	logic [Y_W-1:0] sprite_y;
	logic [COLOR_W-1:0] sprite_color;
	logic sprite_valid;
	logic sprite_done;
	logic [IDX_W-1:0] obj_index;
	logic obj_visible;
	logic [X_W-1:0] obj_x;
	logic [Y_W-1:0] obj_y;
	logic [KIND_W-1:0] obj_kind;
	logic score_add;
	logic [SCORE_W-1:0] score_value;
	logic level_up;

	view_sequencer i_view_sequencer (
		.clk, .resetn, .go, .game_over,
		.bg_x, .bg_y, .bg_valid, .bg_done,
		.sprite_x, .sprite_y, .sprite_color, .sprite_valid, .sprite_done,
		.obj_visible,
		.game_start, .bg_start, .sprite_start, .obj_index,
		.x_out, .y_out, .color_out, .write_en, .frame_done
	);

	background_drawer i_background_drawer (
		.clk, .resetn, .bg_start,
		.bg_x, .bg_y, .bg_valid, .bg_done
	);

	sprite_drawer i_sprite_drawer (
		.clk, .resetn, .sprite_start, .obj_x, .obj_y, .obj_kind,
		.sprite_x, .sprite_y, .sprite_color, .sprite_valid, .sprite_done
	);

	object_map i_object_map (
		.clk, .resetn, .game_start, .level_up, .obj_index, .grab, .grab_index,
		.obj_visible, .obj_x, .obj_y, .obj_kind, .score_add, .score_value
	);

	level_keeper i_level_keeper (
		.clk, .resetn, .game_start, .score_add, .score_value, .frame_done,
		.level_up, .score, .level, .time_left, .game_over
	);

endmodule

`default_nettype wire

/* verilog/gold_view_pkg.sv */
// screen, sprite, object layout, scoring, timer and sequencer state constants
`default_nettype none

package gold_view_pkg;

	// frame buffer geometry
	localparam int X_W = 9;
	localparam int Y_W = 8;
	localparam int COLOR_W = 12;
	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;
	localparam logic [COLOR_W-1:0] BG_COLOR = 12'h741;

	// mined objects
	localparam int SPRITE_SIZE = 16;
	localparam int NUM_GOLD = 5;
	localparam int NUM_STONE = 7;
	localparam int NUM_DIAMOND = 3;
	localparam int NUM_OBJECTS = NUM_GOLD + NUM_STONE + NUM_DIAMOND;
	localparam int IDX_W = 4;

	// object i at column i mod 5, row i div 5
	localparam int MAP_COLS = 5;
	localparam int MAP_X0 = 24;
	localparam int MAP_DX = 56;
	localparam int MAP_Y0 = 96;
	localparam int MAP_DY = 40;

	localparam int KIND_W = 2;
	localparam logic [KIND_W-1:0] KIND_GOLD = 2'd0;
	localparam logic [KIND_W-1:0] KIND_STONE = 2'd1;
	localparam logic [KIND_W-1:0] KIND_DIAMOND = 2'd2;

	localparam logic [COLOR_W-1:0] GOLD_COLOR = 12'hfd0;
	localparam logic [COLOR_W-1:0] STONE_COLOR = 12'h888;
	localparam logic [COLOR_W-1:0] DIAMOND_COLOR = 12'h0ef;

	// scoring and round timing
	localparam int SCORE_W = 10;
	localparam logic [SCORE_W-1:0] GOLD_VALUE = 10'd25;
	localparam logic [SCORE_W-1:0] STONE_VALUE = 10'd5;
	localparam logic [SCORE_W-1:0] DIAMOND_VALUE = 10'd50;
	localparam int LEVEL_W = 3;
	localparam logic [SCORE_W-1:0] GOAL_BASE = 10'd75;
	localparam logic [SCORE_W-1:0] GOAL_STEP = 10'd75;
	localparam int TIME_W = 4;
	localparam logic [TIME_W-1:0] ROUND_FRAMES = 4'd4;

	// view sequencer states
	localparam int STATE_W = 3;
	localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
	localparam logic [STATE_W-1:0] ST_BACKGROUND = 3'd1;
	localparam logic [STATE_W-1:0] ST_FETCH = 3'd2;
	localparam logic [STATE_W-1:0] ST_DRAW = 3'd3;
	localparam logic [STATE_W-1:0] ST_FRAME_END = 3'd4;

endpackage

`default_nettype wire

/* verilog/level_keeper.sv */
// level_keeper score, goal, level, round timer and game over
`default_nettype none

module level_keeper import gold_view_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic               game_start,
	input  logic               score_add,
	input  logic [SCORE_W-1:0] score_value,
	input  logic               frame_done,
	output logic               level_up,
	output logic [SCORE_W-1:0] score,
	output logic [LEVEL_W-1:0] level,
	output logic [TIME_W-1:0]  time_left,
	output logic               game_over
);

	logic [SCORE_W-1:0] goal;
	logic goal_met;

	// goal rises by a fixed step each level
	assign goal = GOAL_BASE + GOAL_STEP * SCORE_W'(level);
	assign goal_met = score >= goal;

	always_ff @(posedge clk) begin
		if (!resetn || game_start) begin
			score <= '0;
			level <= '0;
			time_left <= ROUND_FRAMES;
			game_over <= 1'b0;
			level_up <= 1'b0;
		end else begin
			level_up <= 1'b0;
			if (frame_done) begin
				if (goal_met) begin
					level_up <= 1'b1;
					level <= level + 1'b1;
					score <= '0;
					time_left <= ROUND_FRAMES;
				end else begin
					if (score_add)
						score <= score + score_value;
					time_left <= time_left - 1'b1;
					// last frame of the round just ended
					if (time_left == TIME_W'(1))
						game_over <= 1'b1;
				end
			end else if (score_add) begin
				score <= score + score_value;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/object_map.sv */
// object_map visibility register, layout decode and grab scoring
`default_nettype none

module object_map import gold_view_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic               game_start,
	input  logic               level_up,
	input  logic [IDX_W-1:0]   obj_index,
	input  logic               grab,
	input  logic [IDX_W-1:0]   grab_index,
	output logic               obj_visible,
	output logic [X_W-1:0]     obj_x,
	output logic [Y_W-1:0]     obj_y,
	output logic [KIND_W-1:0]  obj_kind,
	output logic               score_add,
	output logic [SCORE_W-1:0] score_value
);

	logic [NUM_OBJECTS-1:0] visible;
	logic [IDX_W-1:0] col;
	logic [IDX_W-1:0] row;
	logic grab_hit;

	// gold first, then stone, diamonds last
	function automatic logic [KIND_W-1:0] kind_of(input logic [IDX_W-1:0] idx);
		if (idx < IDX_W'(NUM_GOLD))
			return KIND_GOLD;
		else if (idx < IDX_W'(NUM_GOLD + NUM_STONE))
			return KIND_STONE;
		else
			return KIND_DIAMOND;
	endfunction

	function automatic logic [SCORE_W-1:0] value_of(input logic [KIND_W-1:0] kind);
		case (kind)
			KIND_GOLD: return GOLD_VALUE;
			KIND_STONE: return STONE_VALUE;
			default: return DIAMOND_VALUE;
		endcase
	endfunction

	assign col = obj_index % IDX_W'(MAP_COLS);
	assign row = obj_index / IDX_W'(MAP_COLS);
	assign obj_x = X_W'(MAP_X0) + X_W'(col) * X_W'(MAP_DX);
	assign obj_y = Y_W'(MAP_Y0) + Y_W'(row) * Y_W'(MAP_DY);
	assign obj_kind = kind_of(obj_index);
	assign obj_visible = (obj_index < IDX_W'(NUM_OBJECTS)) && visible[obj_index];

	// grabbing a hidden or nonexistent object does nothing
	assign grab_hit = grab && (grab_index < IDX_W'(NUM_OBJECTS)) && visible[grab_index];

	// refill wins over a grab in the same cycle
	always_ff @(posedge clk) begin
		if (!resetn || game_start || level_up) begin
			visible <= '1;
			score_add <= 1'b0;
		end else begin
			score_add <= grab_hit;
			if (grab_hit)
				visible[grab_index] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (grab_hit)
			score_value <= value_of(kind_of(grab_index));
	end

endmodule

`default_nettype wire

/* verilog/sprite_drawer.sv */
// sprite_drawer square scan at a latched origin with kind colour
`default_nettype none

module sprite_drawer import gold_view_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic               sprite_start,
	input  logic [X_W-1:0]     obj_x,
	input  logic [Y_W-1:0]     obj_y,
	input  logic [KIND_W-1:0]  obj_kind,
	output logic [X_W-1:0]     sprite_x,
	output logic [Y_W-1:0]     sprite_y,
	output logic [COLOR_W-1:0] sprite_color,
	output logic               sprite_valid,
	output logic               sprite_done
);

	logic [X_W-1:0] origin_x;
	logic [Y_W-1:0] origin_y;
	logic [KIND_W-1:0] kind;
	logic [3:0] col;
	logic [3:0] row;
	logic col_last;
	logic row_last;

	assign col_last = col == 4'(SPRITE_SIZE - 1);
	assign row_last = row == 4'(SPRITE_SIZE - 1);
	assign sprite_x = origin_x + X_W'(col);
	assign sprite_y = origin_y + Y_W'(row);
	assign sprite_done = sprite_valid && col_last && row_last;

	always_comb begin
		case (kind)
			KIND_GOLD: sprite_color = GOLD_COLOR;
			KIND_STONE: sprite_color = STONE_COLOR;
			default: sprite_color = DIAMOND_COLOR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (sprite_start) begin
			origin_x <= obj_x;
			origin_y <= obj_y;
			kind <= obj_kind;
		end
	end

	// row by row, column offset fastest
	always_ff @(posedge clk) begin
		if (!resetn) begin
			sprite_valid <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (sprite_start) begin
			sprite_valid <= 1'b1;
			col <= '0;
			row <= '0;
		end else if (sprite_valid) begin
			col <= col + 1'b1;
			if (col_last) begin
				row <= row + 1'b1;
				if (row_last)
					sprite_valid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/view_sequencer.sv */
// view_sequencer frame FSM and registered pixel output mux
`default_nettype none

module view_sequencer import gold_view_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic               go,
	input  logic               game_over,
	input  logic [X_W-1:0]     bg_x,
	input  logic [Y_W-1:0]     bg_y,
	input  logic               bg_valid,
	input  logic               bg_done,
	input  logic [X_W-1:0]     sprite_x,
	input  logic [Y_W-1:0]     sprite_y,
	input  logic [COLOR_W-1:0] sprite_color,
	input  logic               sprite_valid,
	input  logic               sprite_done,
	input  logic               obj_visible,
	output logic               game_start,
	output logic               bg_start,
	output logic               sprite_start,
	output logic [IDX_W-1:0]   obj_index,
	output logic [X_W-1:0]     x_out,
	output logic [Y_W-1:0]     y_out,
	output logic [COLOR_W-1:0] color_out,
	output logic               write_en,
	output logic               frame_done
);

	logic [STATE_W-1:0] state;
	logic last_obj;

	assign last_obj = obj_index == IDX_W'(NUM_OBJECTS - 1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
			obj_index <= '0;
			game_start <= 1'b0;
			bg_start <= 1'b0;
			sprite_start <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			// start pulses last one cycle
			game_start <= 1'b0;
			bg_start <= 1'b0;
			sprite_start <= 1'b0;
			frame_done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (go) begin
						game_start <= 1'b1;
						bg_start <= 1'b1;
						state <= ST_BACKGROUND;
					end
				end
				ST_BACKGROUND: begin
					if (bg_done) begin
						obj_index <= '0;
						state <= ST_FETCH;
					end
				end
				ST_FETCH: begin
					// hidden objects cost a single cycle here
					if (obj_visible) begin
						sprite_start <= 1'b1;
						state <= ST_DRAW;
					end else if (last_obj) begin
						frame_done <= 1'b1;
						state <= ST_FRAME_END;
					end else begin
						obj_index <= obj_index + 1'b1;
					end
				end
				ST_DRAW: begin
					if (sprite_done) begin
						if (last_obj) begin
							frame_done <= 1'b1;
							state <= ST_FRAME_END;
						end else begin
							obj_index <= obj_index + 1'b1;
							state <= ST_FETCH;
						end
					end
				end
				ST_FRAME_END: begin
					// second cycle sees the level keeper's updated game_over
					if (!frame_done) begin
						if (game_over) begin
							state <= ST_IDLE;
						end else begin
							bg_start <= 1'b1;
							state <= ST_BACKGROUND;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			write_en <= 1'b0;
		else
			write_en <= (state == ST_BACKGROUND && bg_valid) || (state == ST_DRAW && sprite_valid);
	end

	// pixel payload follows whichever drawer is active
	always_ff @(posedge clk) begin
		if (state == ST_DRAW) begin
			x_out <= sprite_x;
			y_out <= sprite_y;
			color_out <= sprite_color;
		end else begin
			x_out <= bg_x;
			y_out <= bg_y;
			color_out <= BG_COLOR;
		end
	end

endmodule

`default_nettype wire
